// File: logic/la_pipe_pkg.sv
package la_pipe_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;    // data, instruction and pc
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      imm_t;     // already extended to full width

    // first fetch address after reset
    localparam word_t RESET_PC = 32'h1c00_0000;
    localparam word_t PC_STEP  = 32'd4;

    // multiplier retires this many multiplier bits per cycle
    localparam int MUL_STEP_BITS = 8;
    localparam int MUL_CYCLES    = 4;    // 32 / 8, the operand load does the first step
    localparam int MUL_CNT_W     = $clog2(MUL_CYCLES);

    // 3R format, match on inst[31:15]
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [16:0] OPC_MUL_W   = 17'h00038;
    localparam logic [16:0] OPC_MULH_W  = 17'h00039;
    localparam logic [16:0] OPC_MULH_WU = 17'h0003a;

    // 2RI12 format, match on inst[31:22]
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;

    // 1RI20 format, match on inst[31:25]
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

    // execute operation carried down the pipe
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_MUL_LO,     // mul.w
        OP_MUL_HI_S,   // mulh.w
        OP_MUL_HI_U,   // mulh.wu
        OP_NONE        // undecoded, travels as a bubble
    } alu_op_e;

endpackage

// File: logic/inst_decode.sv
`timescale 1ns/10ps

module inst_decode
    import la_pipe_pkg::*;
(
    input  word_t    inst_i,
    output reg_idx_t rj_o,
    output reg_idx_t rk_o,
    output reg_idx_t rd_o,
    output imm_t     imm_o,
    output logic     use_imm_o,
    output alu_op_e  alu_op_o,
    output logic     rf_we_o
);

    imm_t si12_ext;
    imm_t si20_shl;
    logic is_lu12i;
    logic is_addi;

    // register fields sit at the same place in every kept format
    assign rd_o = inst_i[4:0];
    assign rj_o = inst_i[9:5];
    assign rk_o = inst_i[14:10];

    assign si12_ext = {{20{inst_i[21]}}, inst_i[21:10]};
    assign si20_shl = {inst_i[24:5], 12'b0};   // lu12i.w value

    assign is_lu12i = (inst_i[31:25] == OPC_LU12I_W);
    assign is_addi  = (inst_i[31:22] == OPC_ADDI_W);

    always_comb
    begin
        alu_op_o  = OP_NONE;
        use_imm_o = 1'b0;
        imm_o     = si12_ext;

        if (is_lu12i)
        begin
            alu_op_o  = OP_LUI;
            use_imm_o = 1'b1;
            imm_o     = si20_shl;
        end
        else if (is_addi)
        begin
            alu_op_o  = OP_ADD;
            use_imm_o = 1'b1;
        end
        else
        begin
            // register-register group
            case (inst_i[31:15])
                OPC_ADD_W:   alu_op_o = OP_ADD;
                OPC_SUB_W:   alu_op_o = OP_SUB;
                OPC_SLT:     alu_op_o = OP_SLT;
                OPC_SLTU:    alu_op_o = OP_SLTU;
                OPC_AND:     alu_op_o = OP_AND;
                OPC_OR:      alu_op_o = OP_OR;
                OPC_XOR:     alu_op_o = OP_XOR;
                OPC_MUL_W:   alu_op_o = OP_MUL_LO;
                OPC_MULH_W:  alu_op_o = OP_MUL_HI_S;
                OPC_MULH_WU: alu_op_o = OP_MUL_HI_U;
                default:     alu_op_o = OP_NONE;
            endcase
        end
    end

    // every kept instruction writes rd, an unknown word writes nothing
    assign rf_we_o = (alu_op_o != OP_NONE);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import la_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    input  reg_idx_t waddr_i,
    input  logic     we_i,
    input  word_t    wdata_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    word_t regs_q [1:31];   // r0 has no storage

    // r0 reads zero, a same-cycle write is passed straight through
    function automatic word_t read_port(reg_idx_t addr);
        word_t val;
        if (addr == '0)
            val = '0;
        else if (we_i && (waddr_i == addr))
            val = wdata_i;
        else
            val = regs_q[addr];
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end
        else if (we_i && (waddr_i != '0))
            regs_q[waddr_i] <= wdata_i;
    end

    always_comb
    begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/10ps

module alu
    import la_pipe_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    word_t sum;
    word_t diff;
    logic  lt_s;
    logic  lt_u;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    // compares for slt and sltu
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb
    begin
        case (op_i)
            OP_ADD:
                result_o = sum;     // add.w and addi.w
            OP_SUB:
                result_o = diff;
            OP_AND:
                result_o = a_i & b_i;
            OP_OR:
                result_o = a_i | b_i;
            OP_XOR:
                result_o = a_i ^ b_i;
            OP_SLT:
                result_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU:
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            OP_LUI:
                result_o = b_i;     // immediate comes in pre-shifted
            default:
                result_o = '0;      // multiplies and bubbles
        endcase
    end

endmodule

// File: logic/mul_unit.sv
`timescale 1ns/10ps

module mul_unit
    import la_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  mul_start_i,
    input  logic  signed_i,
    input  word_t a_i,
    input  word_t b_i,
    output word_t prod_hi_o,
    output word_t prod_lo_o,
    output logic  mul_done_o
);

    logic [2*XLEN-1:0]    acc_q;     // unsigned partial product
    logic [2*XLEN-1:0]    mcand_q;   // multiplicand, pre-shifted per step
    logic [2*XLEN-1:0]    prod;
    word_t                mplier_q;  // multiplier bits still to consume
    word_t                mag_a;
    word_t                mag_b;
    logic                 neg_q;
    logic                 busy_q;
    logic                 done_q;
    logic                 load;
    logic [MUL_CNT_W-1:0] cnt_q;

    // work on magnitudes, sign is put back on the way out
    assign mag_a = (signed_i && a_i[XLEN-1]) ? -a_i : a_i;
    assign mag_b = (signed_i && b_i[XLEN-1]) ? -b_i : b_i;

    assign load = mul_start_i & ~busy_q & ~done_q;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end
        else if (!mul_start_i)
        begin
            busy_q <= 1'b0;   // request dropped
            done_q <= 1'b0;
        end
        else if (load)
        begin
            busy_q <= 1'b1;
            cnt_q  <= MUL_CNT_W'(MUL_CYCLES - 1);
        end
        else if (busy_q)
        begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == MUL_CNT_W'(1))
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
        else
            done_q <= 1'b0;   // result taken this cycle, next start is a new op
    end

    // first byte of the multiplier is consumed while loading
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            acc_q    <= {{XLEN{1'b0}}, mag_a} * mag_b[MUL_STEP_BITS-1:0];
            mcand_q  <= {{XLEN{1'b0}}, mag_a} << MUL_STEP_BITS;
            mplier_q <= mag_b >> MUL_STEP_BITS;
            neg_q    <= signed_i & (a_i[XLEN-1] ^ b_i[XLEN-1]);
        end
        else if (busy_q)
        begin
            acc_q    <= acc_q + mcand_q * mplier_q[MUL_STEP_BITS-1:0];
            mcand_q  <= mcand_q << MUL_STEP_BITS;
            mplier_q <= mplier_q >> MUL_STEP_BITS;
        end
    end

    assign prod       = neg_q ? -acc_q : acc_q;
    assign prod_hi_o  = prod[2*XLEN-1:XLEN];
    assign prod_lo_o  = prod[XLEN-1:0];
    assign mul_done_o = done_q;

endmodule

// File: logic/la_pipe_top.sv
`timescale 1ns/10ps

module la_pipe_top
    import la_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     inst_valid_i,
    input  word_t    inst_i,
    output logic     inst_ready_o,
    output logic     trace_valid_o,
    output word_t    trace_pc_o,
    output logic     trace_we_o,
    output reg_idx_t trace_rd_o,
    output word_t    trace_wdata_o
);

    word_t    pc_q;
    logic     run_q;     // low until the first edge after reset
    logic     accept;

    // decode stage, straight off the input port
    reg_idx_t dec_rj, dec_rk, dec_rd;
    imm_t     dec_imm;
    logic     dec_use_imm;
    alu_op_e  dec_op;
    logic     dec_we;
    word_t    rf_rdata1, rf_rdata2;

    // execute stage
    logic     ex_valid_q;
    word_t    ex_pc_q;
    reg_idx_t ex_rj_q, ex_rk_q, ex_rd_q;
    logic     ex_we_q;
    alu_op_e  ex_op_q;
    word_t    ex_rj_data_q, ex_rk_data_q;
    imm_t     ex_imm_q;
    logic     ex_use_imm_q;
    word_t    opnd_a, opnd_rk, opnd_b;
    word_t    alu_res, ex_result;
    word_t    prod_hi, prod_lo;
    logic     ex_is_mul, mul_done, ex_stall;

    // memory and writeback stages
    logic     mem_valid_q, mem_we_q;
    word_t    mem_pc_q, mem_res_q;
    reg_idx_t mem_rd_q;
    logic     wb_valid_q, wb_we_q;
    word_t    wb_pc_q, wb_res_q;
    reg_idx_t wb_rd_q;

    // younger stage wins, r0 never forwards
    function automatic word_t fwd_operand(reg_idx_t idx, word_t rf_val);
        word_t val;
        val = rf_val;
        if ((idx != '0) && wb_valid_q && wb_we_q && (wb_rd_q == idx))
            val = wb_res_q;
        if ((idx != '0) && mem_valid_q && mem_we_q && (mem_rd_q == idx))
            val = mem_res_q;
        return val;
    endfunction

    assign ex_is_mul    = ex_valid_q & (ex_op_q inside {OP_MUL_LO, OP_MUL_HI_S, OP_MUL_HI_U});
    assign ex_stall     = ex_is_mul & ~mul_done;
    assign inst_ready_o = run_q & ~ex_stall;
    assign accept       = inst_valid_i & inst_ready_o;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            run_q <= 1'b0;
            pc_q  <= RESET_PC;
        end
        else
        begin
            run_q <= 1'b1;
            if (accept)
                pc_q <= pc_q + PC_STEP;
        end
    end

    inst_decode u_inst_decode (
        .inst_i    (inst_i),
        .rj_o      (dec_rj),
        .rk_o      (dec_rk),
        .rd_o      (dec_rd),
        .imm_o     (dec_imm),
        .use_imm_o (dec_use_imm),
        .alu_op_o  (dec_op),
        .rf_we_o   (dec_we)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (dec_rj),
        .raddr2_i (dec_rk),
        .waddr_i  (wb_rd_q),
        .we_i     (wb_valid_q & wb_we_q),
        .wdata_i  (wb_res_q),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // decode to execute, held while a multiply is running
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ex_valid_q <= 1'b0;
            ex_we_q    <= 1'b0;
            ex_op_q    <= OP_NONE;
        end
        else if (!ex_stall)
        begin
            ex_valid_q <= accept & (dec_op != OP_NONE);   // unknown word becomes a bubble
            ex_we_q    <= dec_we;
            ex_op_q    <= dec_op;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!ex_stall)
        begin
            ex_pc_q      <= pc_q;
            ex_rj_q      <= dec_rj;
            ex_rk_q      <= dec_rk;
            ex_rd_q      <= dec_rd;
            ex_rj_data_q <= rf_rdata1;
            ex_rk_data_q <= rf_rdata2;
            ex_imm_q     <= dec_imm;
            ex_use_imm_q <= dec_use_imm;
        end
    end

    always_comb
    begin
        opnd_a  = fwd_operand(ex_rj_q, ex_rj_data_q);
        opnd_rk = fwd_operand(ex_rk_q, ex_rk_data_q);
    end

    assign opnd_b = ex_use_imm_q ? ex_imm_q : opnd_rk;

    alu u_alu (
        .op_i     (ex_op_q),
        .a_i      (opnd_a),
        .b_i      (opnd_b),
        .result_o (alu_res)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mul_start_i (ex_is_mul),
        .signed_i    (ex_op_q == OP_MUL_HI_S),   // low half is sign independent
        .a_i         (opnd_a),
        .b_i         (opnd_rk),
        .prod_hi_o   (prod_hi),
        .prod_lo_o   (prod_lo),
        .mul_done_o  (mul_done)
    );

    always_comb
    begin
        case (ex_op_q)
            OP_MUL_LO:                ex_result = prod_lo;
            OP_MUL_HI_S, OP_MUL_HI_U: ex_result = prod_hi;
            default:                  ex_result = alu_res;
        endcase
    end

    // execute to memory and memory to writeback
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            mem_valid_q <= 1'b0;
            mem_we_q    <= 1'b0;
            wb_valid_q  <= 1'b0;
            wb_we_q     <= 1'b0;
        end
        else
        begin
            mem_valid_q <= ex_valid_q & ~ex_stall;   // bubble while the multiplier works
            mem_we_q    <= ex_we_q;
            wb_valid_q  <= mem_valid_q;
            wb_we_q     <= mem_we_q;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_pc_q  <= ex_pc_q;
        mem_rd_q  <= ex_rd_q;
        mem_res_q <= ex_result;
        wb_pc_q   <= mem_pc_q;
        wb_rd_q   <= mem_rd_q;
        wb_res_q  <= mem_res_q;
    end

    // trace shows the write on the edge it lands in the register file
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            trace_valid_o <= 1'b0;
            trace_we_o    <= 1'b0;
        end
        else
        begin
            trace_valid_o <= wb_valid_q;
            trace_we_o    <= wb_valid_q & wb_we_q & (wb_rd_q != '0);
        end
    end

    always_ff @(posedge clk)
    begin
        trace_pc_o    <= wb_pc_q;
        trace_rd_o    <= wb_rd_q;
        trace_wdata_o <= wb_res_q;
    end

endmodule

// File: dv/la_pipe_assert.sv
`timescale 1ns/10ps

module la_pipe_assert
    import la_pipe_pkg::*;
(
    input logic  clk,
    input logic  rst_n_i,
    input logic  inst_valid_i,
    input word_t inst_i,
    input logic  inst_ready_o,
    input logic  trace_valid_o,
    input logic  trace_we_o
);

    // nothing is taken while reset is held
    ready_in_reset: assert property (@(posedge clk) !rst_n_i |-> !inst_ready_o)
        else $error("inst_ready_o high while rst_n_i is low");

    // pipe is empty on the first cycle out of reset
    trace_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !trace_valid_o)
        else $error("trace_valid_o high on the first cycle after reset");

    // an offered instruction waits unchanged for ready
    inst_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_valid_i && !inst_ready_o) |=> $stable(inst_i))
        else $error("inst_i changed while waiting for inst_ready_o");

    trace_we_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        trace_we_o |-> trace_valid_o)
        else $error("trace_we_o high without trace_valid_o");

endmodule

// File: dv/la_pipe_tb.sv
`timescale 1ns/10ps

module la_pipe_tb
    import la_pipe_pkg::*;
();

    localparam int PROG_LEN        = 24;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = PROG_LEN * (4 + MUL_CYCLES) + 200;
    localparam int DRAIN_CYCLES    = 12;   // room for a stray late pulse

    logic     clk;
    logic     rst_n_i;
    logic     inst_valid_i;
    word_t    inst_i;
    logic     inst_ready_o;
    logic     trace_valid_o;
    word_t    trace_pc_o;
    logic     trace_we_o;
    reg_idx_t trace_rd_o;
    word_t    trace_wdata_o;

    word_t    prog_inst  [PROG_LEN];
    logic     prog_trace [PROG_LEN];   // low for an undecoded word
    logic     prog_we    [PROG_LEN];
    reg_idx_t prog_rd    [PROG_LEN];
    word_t    prog_wdata [PROG_LEN];
    int       n_entries;

    // trace pulses in arrival order
    word_t    seen_pc    [$];
    logic     seen_we    [$];
    reg_idx_t seen_rd    [$];
    word_t    seen_wdata [$];

    logic [31:0] lfsr_q;
    int          word_errors;
    int          idx_errors;
    int          bit_errors;
    int          other_errors;

    la_pipe_top u_la_pipe_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_ready_o  (inst_ready_o),
        .trace_valid_o (trace_valid_o),
        .trace_pc_o    (trace_pc_o),
        .trace_we_o    (trace_we_o),
        .trace_rd_o    (trace_rd_o),
        .trace_wdata_o (trace_wdata_o)
    );

    bind la_pipe_top la_pipe_assert u_la_pipe_assert (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_ready_o  (inst_ready_o),
        .trace_valid_o (trace_valid_o),
        .trace_we_o    (trace_we_o)
    );

    always #20 clk = ~clk;

    function automatic word_t enc_3r(logic [16:0] opc, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic word_t enc_addi(reg_idx_t rd, reg_idx_t rj, logic [11:0] si12);
        return {OPC_ADDI_W, si12, rj, rd};
    endfunction

    function automatic word_t enc_lu12i(reg_idx_t rd, logic [19:0] si20);
        return {OPC_LU12I_W, si20, rd};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = (val << 1) | lfsr_q[0];
        end
    endtask

    task automatic add_entry(input word_t inst, input logic has_trace, input logic we,
                             input reg_idx_t rd, input word_t wdata);
        prog_inst[n_entries]  = inst;
        prog_trace[n_entries] = has_trace;
        prog_we[n_entries]    = we;
        prog_rd[n_entries]    = rd;
        prog_wdata[n_entries] = wdata;
        n_entries++;
    endtask

    // expected values from the instruction semantics
    task automatic load_program();
        add_entry(enc_lu12i(5'd1, 20'h12345), 1'b1, 1'b1, 5'd1, 32'h1234_5000);
        add_entry(enc_addi(5'd1, 5'd1, 12'h678), 1'b1, 1'b1, 5'd1, 32'h1234_5678);
        add_entry(enc_addi(5'd2, 5'd0, 12'hfff), 1'b1, 1'b1, 5'd2, 32'hffff_ffff);
        add_entry(enc_3r(OPC_ADD_W, 5'd3, 5'd1, 5'd2), 1'b1, 1'b1, 5'd3, 32'h1234_5677);
        add_entry(enc_3r(OPC_SUB_W, 5'd4, 5'd3, 5'd1), 1'b1, 1'b1, 5'd4, 32'hffff_ffff);
        add_entry(enc_3r(OPC_AND, 5'd5, 5'd1, 5'd4), 1'b1, 1'b1, 5'd5, 32'h1234_5678);
        add_entry(enc_3r(OPC_OR, 5'd6, 5'd5, 5'd3), 1'b1, 1'b1, 5'd6, 32'h1234_567f);
        add_entry(enc_3r(OPC_XOR, 5'd7, 5'd6, 5'd1), 1'b1, 1'b1, 5'd7, 32'h0000_0007);
        add_entry(enc_3r(OPC_SLT, 5'd8, 5'd2, 5'd7), 1'b1, 1'b1, 5'd8, 32'h0000_0001);
        add_entry(enc_3r(OPC_SLTU, 5'd9, 5'd2, 5'd7), 1'b1, 1'b1, 5'd9, 32'h0000_0000);
        add_entry(32'hffff_ffff, 1'b0, 1'b0, 5'd0, 32'h0);
        add_entry(enc_addi(5'd10, 5'd0, 12'hffd), 1'b1, 1'b1, 5'd10, 32'hffff_fffd);
        add_entry(enc_addi(5'd11, 5'd0, 12'h007), 1'b1, 1'b1, 5'd11, 32'h0000_0007);
        add_entry(enc_3r(OPC_MUL_W, 5'd12, 5'd10, 5'd11), 1'b1, 1'b1, 5'd12, 32'hffff_ffeb);
        add_entry(enc_3r(OPC_MULH_W, 5'd13, 5'd10, 5'd11), 1'b1, 1'b1, 5'd13, 32'hffff_ffff);
        add_entry(enc_3r(OPC_MULH_WU, 5'd14, 5'd10, 5'd11), 1'b1, 1'b1, 5'd14, 32'h0000_0006);
        add_entry(enc_3r(OPC_MULH_WU, 5'd15, 5'd2, 5'd2), 1'b1, 1'b1, 5'd15, 32'hffff_fffe);
        add_entry(enc_3r(OPC_MUL_W, 5'd16, 5'd15, 5'd14), 1'b1, 1'b1, 5'd16, 32'hffff_fff4);
        add_entry(enc_3r(OPC_MULH_W, 5'd17, 5'd1, 5'd11), 1'b1, 1'b1, 5'd17, 32'h0000_0000);
        add_entry(enc_3r(OPC_MULH_W, 5'd18, 5'd10, 5'd1), 1'b1, 1'b1, 5'd18, 32'hffff_ffff);
        add_entry(enc_addi(5'd0, 5'd1, 12'h005), 1'b1, 1'b0, 5'd0, 32'h0);   // r0 write
        add_entry(enc_3r(OPC_ADD_W, 5'd19, 5'd0, 5'd1), 1'b1, 1'b1, 5'd19, 32'h1234_5678);
        add_entry(32'h0000_0000, 1'b0, 1'b0, 5'd0, 32'h0);
        add_entry(enc_3r(OPC_ADD_W, 5'd20, 5'd19, 5'd16), 1'b1, 1'b1, 5'd20, 32'h1234_566c);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            word_errors++;
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t expected, input reg_idx_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            idx_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
            bit_errors++;
        end
    endtask

    // called just after a rising edge, returns just after the edge that took it
    task automatic offer_instruction(input word_t inst);
        logic taken;
        taken        = 1'b0;
        inst_valid_i = 1'b1;
        inst_i       = inst;
        while (!taken)
        begin
            @(negedge clk);
            taken = inst_ready_o;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic idle_cycles(input int n);
        inst_valid_i = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic compare_trace(input int n_exp);
        int k;
        k = 0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            if (prog_trace[i] && (k < seen_pc.size()))
            begin
                check_word($sformatf("inst %0d pc", i), RESET_PC + PC_STEP * word_t'(i),
                           seen_pc[k]);
                check_bit($sformatf("inst %0d we", i), prog_we[i], seen_we[k]);
                check_idx($sformatf("inst %0d rd", i), prog_rd[i], seen_rd[k]);
                if (prog_we[i])
                    check_word($sformatf("inst %0d wdata", i), prog_wdata[i], seen_wdata[k]);
            end
            if (prog_trace[i])
                k++;
        end
        if (seen_pc.size() != n_exp)
        begin
            $display("saw %0d trace pulses but %0d were due", seen_pc.size(), n_exp);
            other_errors++;
        end
    endtask

    // sample away from the edge the outputs change on
    always @(negedge clk)
    begin
        if (rst_n_i && trace_valid_o)
        begin
            seen_pc.push_back(trace_pc_o);
            seen_we.push_back(trace_we_o);
            seen_rd.push_back(trace_rd_o);
            seen_wdata.push_back(trace_wdata_o);
        end
    end

    initial
    begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the trace stalled after %0d pulses", seen_pc.size());
        $display("errors: word %0d idx %0d bit %0d other %0d",
                 word_errors, idx_errors, bit_errors, other_errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        int gap;
        int n_exp;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        lfsr_q       = 32'h1bd5;
        n_entries    = 0;
        word_errors  = 0;
        idx_errors   = 0;
        bit_errors   = 0;
        other_errors = 0;
        n_exp        = 0;

        load_program();
        for (int i = 0; i < PROG_LEN; i++)
            n_exp += prog_trace[i];

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        for (int i = 0; i < PROG_LEN; i++)
        begin
            take_random(2, gap);   // 0 to 3 idle cycles
            if (gap > 0)
                idle_cycles(gap);
            offer_instruction(prog_inst[i]);
        end
        inst_valid_i = 1'b0;

        while (seen_pc.size() < n_exp)
            @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);

        compare_trace(n_exp);
        $display("errors: word %0d idx %0d bit %0d other %0d",
                 word_errors, idx_errors, bit_errors, other_errors);
        if ((word_errors + idx_errors + bit_errors + other_errors) == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: la_pipe.f
logic/la_pipe_pkg.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/mul_unit.sv
logic/la_pipe_top.sv
dv/la_pipe_assert.sv
dv/la_pipe_tb.sv
